/* rtl/reference_pkg.sv */
// ####################
// Reference package
// Shared widths, sample structs and the angle source select for the
// multiphase current reference generator
// ####################

package reference_pkg;

    // Fixed by the sine table format
    localparam int DATA_WIDTH = 16;

    // A full electrical turn spans the whole angle range
    localparam int ANGLE_WIDTH = 16;

    localparam int MAX_PHASES = 16;
    localparam int PHASE_INDEX_WIDTH = $clog2(MAX_PHASES);

    typedef logic [PHASE_INDEX_WIDTH-1:0] phase_index_t;

    typedef enum logic {
        ANGLE_EXTERNAL,
        ANGLE_EMULATED
    } angle_source_t;

    // Angle together with the current setpoints sampled with it
    typedef struct packed {
        logic [ANGLE_WIDTH-1:0] angle;
        logic signed [DATA_WIDTH-1:0] id;
        logic signed [DATA_WIDTH-1:0] iq;
    } angle_sample_t;

    // One phase worth of sinusoids plus the setpoints they are combined with
    typedef struct packed {
        phase_index_t phase;
        logic signed [DATA_WIDTH-1:0] sin;
        logic signed [DATA_WIDTH-1:0] cos;
        logic signed [DATA_WIDTH-1:0] id;
        logic signed [DATA_WIDTH-1:0] iq;
    } sinusoid_sample_t;

    // Output word tagged with its phase number
    typedef struct packed {
        phase_index_t phase;
        logic signed [DATA_WIDTH-1:0] value;
    } reference_word_t;

endpackage

/* rtl/sine_rom.sv */
// ####################
// Sine ROM
// Quarter-wave table folded by quadrant, sine and cosine read per cycle
// ####################

module sine_rom (
    input  logic clock,
    input  logic [reference_pkg::ANGLE_WIDTH-1:0] sin_angle,
    input  logic [reference_pkg::ANGLE_WIDTH-1:0] cos_angle,
    output logic signed [reference_pkg::DATA_WIDTH-1:0] sin_value,
    output logic signed [reference_pkg::DATA_WIDTH-1:0] cos_value
);
    import reference_pkg::*;

    // First quadrant only, sampled at the middle of each step
    logic [DATA_WIDTH-1:0] quarter_table [0:31];

    initial begin
        $readmemh("rtl/sine_quarter.hex", quarter_table);
    end

    // Bit 14 mirrors the index inside a quadrant, bit 15 flips the sign
    function automatic logic signed [DATA_WIDTH-1:0] fold(input logic [ANGLE_WIDTH-1:0] angle);
        logic [4:0] index;
        logic [DATA_WIDTH-1:0] magnitude;
        index = angle[13:9];
        if (angle[14]) begin
            index = 5'd31 - index;
        end
        magnitude = quarter_table[index];
        if (angle[15]) begin
            fold = -signed'(magnitude);
        end else begin
            fold = signed'(magnitude);
        end
    endfunction

    always_ff @(posedge clock) begin
        sin_value <= fold(sin_angle);
        cos_value <= fold(cos_angle);
    end

endmodule

/* rtl/angle_source.sv */
// ####################
// Angle source
// Picks the external or emulated angle and samples the current setpoints
// ####################

module angle_source (
    input  logic clock,
    input  logic reset,
    input  reference_pkg::angle_source_t source,
    input  logic [15:0] emulation_period,
    input  logic [15:0] emulation_advance,
    input  logic [reference_pkg::ANGLE_WIDTH-1:0] phase,
    input  logic phase_valid,
    input  logic signed [reference_pkg::DATA_WIDTH-1:0] id,
    input  logic signed [reference_pkg::DATA_WIDTH-1:0] iq,
    output reference_pkg::angle_sample_t angle_sample,
    output logic angle_valid
);
    import reference_pkg::*;

    logic [15:0] tick_count;
    logic [16:0] next_tick;
    logic [ANGLE_WIDTH-1:0] emulated_angle;
    logic [ANGLE_WIDTH-1:0] selected_angle;

    // A period of zero behaves like a period of one
    assign next_tick = {1'b0, tick_count} + 17'd1;

    assign selected_angle = (source == ANGLE_EMULATED) ? emulated_angle : phase;

    // Emulator runs only while selected and restarts from zero each time
    always_ff @(posedge clock) begin
        if (!reset) begin
            tick_count <= '0;
            emulated_angle <= '0;
        end else if (source != ANGLE_EMULATED) begin
            tick_count <= '0;
            emulated_angle <= '0;
        end else if (next_tick >= {1'b0, emulation_period}) begin
            tick_count <= '0;
            emulated_angle <= emulated_angle + emulation_advance;
        end else begin
            tick_count <= next_tick[15:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            angle_valid <= 1'b0;
        end else begin
            angle_valid <= phase_valid;
        end
    end

    // Setpoints are captured with the angle so the sweep uses a matching set
    always_ff @(posedge clock) begin
        if (phase_valid) begin
            angle_sample.angle <= selected_angle;
            angle_sample.id <= id;
            angle_sample.iq <= iq;
        end
    end

endmodule

/* rtl/phase_sinusoid_generator.sv */
// ####################
// Phase sinusoid generator
// Sweeps all phases for each angle, producing sine and cosine per phase
// ####################

module phase_sinusoid_generator #(
    parameter int N_PHASES = 6
) (
    input  logic clock,
    input  logic reset,
    input  reference_pkg::angle_sample_t angle_sample,
    input  logic angle_valid,
    input  logic [N_PHASES-1:0][reference_pkg::ANGLE_WIDTH-1:0] phase_shifts,
    output reference_pkg::sinusoid_sample_t sinusoid,
    output logic sinusoid_valid
);
    import reference_pkg::*;

    localparam phase_index_t LAST_PHASE = phase_index_t'(N_PHASES - 1);

    logic busy;
    logic start;
    logic active;
    phase_index_t phase_count;
    phase_index_t rom_phase;
    angle_sample_t held_sample;
    angle_sample_t rom_sample;
    logic [ANGLE_WIDTH-1:0] shifted_angle;
    logic [ANGLE_WIDTH-1:0] quadrature_angle;
    logic signed [DATA_WIDTH-1:0] sin_value;
    logic signed [DATA_WIDTH-1:0] cos_value;

    // Data travelling next to the ROM read
    logic stage_valid;
    phase_index_t stage_phase;
    logic signed [DATA_WIDTH-1:0] stage_id;
    logic signed [DATA_WIDTH-1:0] stage_iq;

    // Phase 0 goes to the ROM in the same cycle as the accepted angle
    assign start = angle_valid && !busy;
    assign active = start || busy;
    assign rom_phase = start ? '0 : phase_count;
    assign rom_sample = start ? angle_sample : held_sample;

    assign shifted_angle = rom_sample.angle + phase_shifts[rom_phase];
    assign quadrature_angle = shifted_angle + ANGLE_WIDTH'(16384);

    sine_rom rom (
        .clock(clock),
        .sin_angle(shifted_angle),
        .cos_angle(quadrature_angle),
        .sin_value(sin_value),
        .cos_value(cos_value)
    );

    always_ff @(posedge clock) begin
        if (!reset) begin
            busy <= 1'b0;
            phase_count <= '0;
        end else if (active) begin
            if (rom_phase == LAST_PHASE) begin
                busy <= 1'b0;
                phase_count <= '0;
            end else begin
                busy <= 1'b1;
                phase_count <= rom_phase + phase_index_t'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            held_sample <= angle_sample;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            stage_valid <= 1'b0;
            sinusoid_valid <= 1'b0;
        end else begin
            stage_valid <= active;
            sinusoid_valid <= stage_valid;
        end
    end

    always_ff @(posedge clock) begin
        stage_phase <= rom_phase;
        stage_id <= rom_sample.id;
        stage_iq <= rom_sample.iq;
        sinusoid.phase <= stage_phase;
        sinusoid.sin <= sin_value;
        sinusoid.cos <= cos_value;
        sinusoid.id <= stage_id;
        sinusoid.iq <= stage_iq;
    end

endmodule

/* rtl/reference_combiner.sv */
// ####################
// Reference combiner
// Inverse Park transform per phase and the per-phase reference store
// ####################

module reference_combiner #(
    parameter int N_PHASES = 6
) (
    input  logic clock,
    input  logic reset,
    input  reference_pkg::sinusoid_sample_t sinusoid,
    input  logic sinusoid_valid,
    output logic signed [N_PHASES-1:0][reference_pkg::DATA_WIDTH-1:0] references
);
    import reference_pkg::*;

    localparam int PRODUCT_WIDTH = 2 * DATA_WIDTH;

    logic signed [PRODUCT_WIDTH-1:0] id_product;
    logic signed [PRODUCT_WIDTH-1:0] iq_product;
    logic signed [PRODUCT_WIDTH-1:0] id_term;
    logic signed [PRODUCT_WIDTH-1:0] iq_term;
    logic signed [PRODUCT_WIDTH-1:0] difference;
    logic signed [DATA_WIDTH-1:0] reference_value;

    // Sine and cosine are Q15, so each product is scaled back by 15 bits
    assign id_product = sinusoid.id * sinusoid.sin;
    assign iq_product = sinusoid.iq * sinusoid.cos;
    assign id_term = id_product >>> (DATA_WIDTH - 1);
    assign iq_term = iq_product >>> (DATA_WIDTH - 1);

    assign difference = id_term - iq_term;

    // Overflow wraps, the setpoints are expected to stay in range
    assign reference_value = difference[DATA_WIDTH-1:0];

    // The whole store is always visible to the serializer
    always_ff @(posedge clock) begin
        if (!reset) begin
            references <= '0;
        end else if (sinusoid_valid) begin
            references[sinusoid.phase] <= reference_value;
        end
    end

endmodule

/* rtl/reference_serializer.sv */
// ####################
// Reference serializer
// Sends the stored references out one phase per cycle after a sync
// ####################

module reference_serializer #(
    parameter int N_PHASES = 6
) (
    input  logic clock,
    input  logic reset,
    input  logic sync,
    input  logic signed [N_PHASES-1:0][reference_pkg::DATA_WIDTH-1:0] references,
    output reference_pkg::reference_word_t reference_out,
    output logic reference_valid
);
    import reference_pkg::*;

    localparam phase_index_t LAST_PHASE = phase_index_t'(N_PHASES - 1);

    logic sync_delay;
    logic bursting;
    phase_index_t out_phase;

    always_ff @(posedge clock) begin
        if (!reset) begin
            sync_delay <= 1'b0;
            bursting <= 1'b0;
            out_phase <= '0;
            reference_valid <= 1'b0;
        end else begin
            sync_delay <= sync;
            reference_valid <= 1'b0;
            // A new sync wins over a burst in progress
            if (sync_delay) begin
                reference_valid <= 1'b1;
                bursting <= (N_PHASES > 1);
                out_phase <= phase_index_t'(1);
            end else if (bursting) begin
                reference_valid <= 1'b1;
                if (out_phase == LAST_PHASE) begin
                    bursting <= 1'b0;
                    out_phase <= '0;
                end else begin
                    out_phase <= out_phase + phase_index_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sync_delay) begin
            reference_out.phase <= '0;
            reference_out.value <= references[0];
        end else begin
            reference_out.phase <= out_phase;
            reference_out.value <= references[out_phase];
        end
    end

endmodule

/* rtl/multiphase_reference_generator.sv */
// ####################
// Multiphase reference generator
// Angle source, phase sweep, inverse Park store and serial readout
// ####################

module multiphase_reference_generator #(
    parameter int N_PHASES = 6
) (
    input  logic clock,
    input  logic reset,
    input  logic sync,
    input  reference_pkg::angle_source_t source,
    input  logic [15:0] emulation_period,
    input  logic [15:0] emulation_advance,
    input  logic [reference_pkg::ANGLE_WIDTH-1:0] phase,
    input  logic phase_valid,
    input  logic signed [reference_pkg::DATA_WIDTH-1:0] id,
    input  logic signed [reference_pkg::DATA_WIDTH-1:0] iq,
    input  logic [N_PHASES-1:0][reference_pkg::ANGLE_WIDTH-1:0] phase_shifts,
    output logic [reference_pkg::ANGLE_WIDTH-1:0] angle_out,
    output logic angle_out_valid,
    output reference_pkg::reference_word_t reference_out,
    output logic reference_valid
);
    import reference_pkg::*;

    angle_sample_t angle_sample;
    logic angle_valid;
    sinusoid_sample_t sinusoid;
    logic sinusoid_valid;
    logic signed [N_PHASES-1:0][DATA_WIDTH-1:0] references;

    // The selected angle is also reported outside
    assign angle_out = angle_sample.angle;
    assign angle_out_valid = angle_valid;

    angle_source source_select (
        .clock(clock),
        .reset(reset),
        .source(source),
        .emulation_period(emulation_period),
        .emulation_advance(emulation_advance),
        .phase(phase),
        .phase_valid(phase_valid),
        .id(id),
        .iq(iq),
        .angle_sample(angle_sample),
        .angle_valid(angle_valid)
    );

    phase_sinusoid_generator #(.N_PHASES(N_PHASES)) generator (
        .clock(clock),
        .reset(reset),
        .angle_sample(angle_sample),
        .angle_valid(angle_valid),
        .phase_shifts(phase_shifts),
        .sinusoid(sinusoid),
        .sinusoid_valid(sinusoid_valid)
    );

    reference_combiner #(.N_PHASES(N_PHASES)) combiner (
        .clock(clock),
        .reset(reset),
        .sinusoid(sinusoid),
        .sinusoid_valid(sinusoid_valid),
        .references(references)
    );

    reference_serializer #(.N_PHASES(N_PHASES)) serializer (
        .clock(clock),
        .reset(reset),
        .sync(sync),
        .references(references),
        .reference_out(reference_out),
        .reference_valid(reference_valid)
    );

endmodule

/* verification/clock_gen.sv */
// ####################
// Clock generator
// Free running testbench clock
// ####################

module clock_gen #(
    parameter int PERIOD = 20
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    always #(PERIOD / 2) clock = ~clock;

endmodule

/* verification/tb_multiphase_reference.sv */
// ####################
// Multiphase reference testbench
// Replays the command file on the DUT and checks angles and serial references
// ####################

module tb_multiphase_reference;
    import reference_pkg::*;

    localparam int N_PHASES = 6;
    localparam int MAX_LINES = 64;

    logic clock;
    logic reset;
    logic sync;
    angle_source_t source;
    logic [15:0] emulation_period;
    logic [15:0] emulation_advance;
    logic [ANGLE_WIDTH-1:0] phase;
    logic phase_valid;
    logic signed [DATA_WIDTH-1:0] id;
    logic signed [DATA_WIDTH-1:0] iq;
    logic [N_PHASES-1:0][ANGLE_WIDTH-1:0] phase_shifts;
    logic [ANGLE_WIDTH-1:0] angle_out;
    logic angle_out_valid;
    reference_word_t reference_out;
    logic reference_valid;

    // One entry per command line of the stimulus file
    logic [63:0] commands [0:MAX_LINES-1];
    logic [31:0] fields [0:MAX_LINES-1][0:9];
    int line_count;
    int cycle_limit = 1000000;
    int cycle_count = 0;
    int error_count;
    int pass_count;
    int fail_count;

    clock_gen #(.PERIOD(20)) clock_source (.clock(clock));

    multiphase_reference_generator #(.N_PHASES(N_PHASES)) DUT (
        .clock(clock),
        .reset(reset),
        .sync(sync),
        .source(source),
        .emulation_period(emulation_period),
        .emulation_advance(emulation_advance),
        .phase(phase),
        .phase_valid(phase_valid),
        .id(id),
        .iq(iq),
        .phase_shifts(phase_shifts),
        .angle_out(angle_out),
        .angle_out_valid(angle_out_valid),
        .reference_out(reference_out),
        .reference_valid(reference_valid)
    );

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the commands did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    // Inputs change a little after the edge so the DUT sees them settled
    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic strobe_angle(input logic [15:0] value, output logic [15:0] angle);
        int latency;
        latency = 0;
        phase = value;
        phase_valid = 1'b1;
        do begin
            next_cycle();
            phase_valid = 1'b0;
            latency++;
        end while (!angle_out_valid && latency < 8);
        if (!angle_out_valid) begin
            $display("No angle_out_valid seen within %0d cycles of phase_valid", latency);
            error_count++;
        end
        check_value("angle_out latency", latency, 1);
        angle = angle_out;
    endtask

    task automatic run_angle(input int idx);
        logic [15:0] angle;
        int k;
        id = fields[idx][1][15:0];
        iq = fields[idx][2][15:0];
        for (k = 0; k < N_PHASES; k++) begin
            phase_shifts[k] = fields[idx][3 + k][15:0];
        end
        strobe_angle(fields[idx][0][15:0], angle);
        check_value("angle_out", angle, fields[idx][0][15:0]);
    endtask

    task automatic run_idle(input int idx);
        int k;
        id = fields[idx][1][15:0];
        iq = fields[idx][2][15:0];
        for (k = 0; k < fields[idx][0]; k++) begin
            next_cycle();
            if (fields[idx][3] != 0) begin
                check_value("reference_valid", reference_valid, 0);
                check_value("angle_out_valid", angle_out_valid, 0);
            end
        end
    endtask

    // A second sync after RESTART words lets one more word out, then phase 0 follows
    task automatic run_sync(input int idx);
        int latency;
        int restart;
        int total;
        int pos;
        int expected_phase;
        restart = fields[idx][0];
        total = (restart > 0) ? restart + 1 + N_PHASES : N_PHASES;
        latency = 0;
        sync = 1'b1;
        do begin
            next_cycle();
            sync = 1'b0;
            latency++;
        end while (!reference_valid && latency < 8);
        if (!reference_valid) begin
            $display("No reference_valid seen within %0d cycles of sync", latency);
            error_count++;
        end
        check_value("reference_out latency", latency, 2);
        for (pos = 0; pos < total; pos++) begin
            expected_phase = (restart > 0 && pos > restart) ? pos - restart - 1 : pos;
            check_value("reference_valid", reference_valid, 1);
            check_value("reference_out.phase", reference_out.phase, expected_phase);
            check_value("reference_out.value", $unsigned(reference_out.value),
                        fields[idx][1 + expected_phase][15:0]);
            sync = (pos + 1 == restart);
            next_cycle();
        end
        sync = 1'b0;
        check_value("reference_valid", reference_valid, 0);
    endtask

    task automatic run_emulate(input int idx);
        logic [15:0] first_angle;
        logic [15:0] second_angle;
        logic [15:0] delta;
        int gap;
        gap = fields[idx][0] * fields[idx][2];
        emulation_period = fields[idx][0][15:0];
        emulation_advance = fields[idx][1][15:0];
        source = ANGLE_EMULATED;
        repeat (3) next_cycle();
        strobe_angle(16'h0000, first_angle);
        // The strobe task already used up one cycle of the gap
        repeat (gap - 1) next_cycle();
        strobe_angle(16'h0000, second_angle);
        delta = second_angle - first_angle;
        check_value("angle_out delta", delta, fields[idx][3][15:0]);
        source = ANGLE_EXTERNAL;
    endtask

    initial begin
        int fd;
        int n;
        int k;
        int test_index;
        int test_errors;
        logic [8*128-1:0] text;
        logic [63:0] word;
        reset = 1'b0;
        sync = 1'b0;
        source = ANGLE_EXTERNAL;
        emulation_period = '0;
        emulation_advance = '0;
        phase = '0;
        phase_valid = 1'b0;
        id = '0;
        iq = '0;
        phase_shifts = '0;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        line_count = 0;

        fd = $fopen("verification/reference_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/reference_stim.txt for reading");
            error_count++;
        end
        while (fd != 0 && !$feof(fd) && line_count < MAX_LINES) begin
            text = '0;
            word = '0;
            n = $fgets(text, fd);
            if (n > 0 && $sscanf(text, "%s", word) == 1 && word != "#") begin
                commands[line_count] = word;
                for (k = 0; k < 10; k++) begin
                    fields[line_count][k] = '0;
                end
                n = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h", word,
                            fields[line_count][0], fields[line_count][1],
                            fields[line_count][2], fields[line_count][3],
                            fields[line_count][4], fields[line_count][5],
                            fields[line_count][6], fields[line_count][7],
                            fields[line_count][8], fields[line_count][9]);
                line_count++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        cycle_limit = 40 * line_count + 200;

        repeat (8) @(posedge clock);
        #2;
        reset = 1'b1;

        for (test_index = 0; test_index < line_count; test_index++) begin
            test_errors = error_count;
            case (commands[test_index])
                "angle": run_angle(test_index);
                "idle": run_idle(test_index);
                "sync": run_sync(test_index);
                "emulate": run_emulate(test_index);
                default: begin
                    $display("Unknown command on stimulus entry %0d", test_index + 1);
                    error_count++;
                end
            endcase
            if (error_count == test_errors) begin
                pass_count++;
                $display("Test %0d %0s: pass", test_index + 1, commands[test_index]);
            end else begin
                fail_count++;
                $display("Test %0d %0s: failed", test_index + 1, commands[test_index]);
            end
        end

        $display("%0d tests run, %0d passed, %0d failed", line_count, pass_count, fail_count);
        if (fail_count == 0 && error_count == 0 && line_count > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* rtl/sine_quarter.hex */
0324
096A
0FAB
15E2
1C0B
2223
2826
2E11
33DF
398C
3F17
447A
49B4
4EBF
539B
5842
5CB3
60EB
64E8
68A6
6C23
6F5E
7254
7504
776B
7989
7B5C
7CE3
7E1D
7F09
7FA6
7FF5

/* all.f */
rtl/reference_pkg.sv
rtl/sine_rom.sv
rtl/angle_source.sv
rtl/phase_sinusoid_generator.sv
rtl/reference_combiner.sv
rtl/reference_serializer.sv
rtl/multiphase_reference_generator.sv
verification/clock_gen.sv
verification/tb_multiphase_reference.sv

/* verification/reference_stim.txt */
# Columns: command, then hex fields that depend on the command
#   angle   PHASE ID IQ SHIFT0 SHIFT1 SHIFT2 SHIFT3 SHIFT4 SHIFT5
#   idle    CYCLES ID IQ QUIET
#   sync    RESTART REF0 REF1 REF2 REF3 REF4 REF5
#   emulate PERIOD ADVANCE MULTIPLE DELTA
# RESTART is the number of words seen before a second sync, 0 for none
# QUIET set means reference_valid and angle_out_valid must stay low

# Nothing comes out after reset and the store reads back as zero
idle A 0000 0000 1
sync 0 0000 0000 0000 0000 0000 0000

# External angle 0x1234 with shifts 60 degrees apart, id 0.5 and iq 0.25
angle 1234 4000 2000 0000 2AAA 5555 8000 AAAA D555
idle C 4000 2000 0
sync 0 0031 3D79 3F04 FFCF C288 C0FD

# Setpoints move right after the strobe, references follow the sampled ones
angle 0000 2000 C000 0000 2AAA 5555 8000 AAAA D555
idle C 7FFF 7FFF 0
sync 0 40C4 3B63 FC4C BF3D C49D 03B4

# Second strobe lands while the sweep for 0x1234 is still running
angle 1234 4000 2000 0000 2AAA 5555 8000 AAAA D555
angle 0000 2000 C000 0000 2AAA 5555 8000 AAAA D555
idle C 4000 2000 0
sync 0 0031 3D79 3F04 FFCF C288 C0FD

# Sync again after three words, the burst restarts at phase 0
sync 3 0031 3D79 3F04 FFCF C288 C0FD

# Emulated angle, strobes three periods of five cycles apart
emulate 5 0123 3 0369
idle A 0000 0000 1
